//--- include/list_walk_cfg.svh
`ifndef LIST_WALK_CFG_SVH
`define LIST_WALK_CFG_SVH

// ==============================
// Address widths
// ==============================

// Host byte address width
`define LW_BYTE_ADDR_W 32

// Bits that select a byte within one 64-byte line
`define LW_LINE_OFS_W 6

// APB address bus width
`define LW_APB_ADDR_W 8

// ==============================
// Walker parameters
// ==============================

// Width of the record and data-word counters
`define LW_CNT_W 16

// Each record spans four lines and line 0 holds the next pointer
`define LW_REC_LINES 4

// Starting value of the hash for every traversal
`define LW_HASH_SEED 32'h0000_0001

// ==============================
// APB register byte offsets
// ==============================

`define LW_REG_RESULT   8'h00
`define LW_REG_START    8'h04
`define LW_REG_LIST_LEN 8'h08
`define LW_REG_DATA_CNT 8'h0C

`endif

//--- list_walk.f
+incdir+include
logic/list_walk_pkg.sv
logic/list_walk_regs.sv
logic/list_walk_ctrl.sv
logic/list_walk_rsp.sv
logic/list_walk_top.sv
sim/list_walk_sva.sv
sim/list_walk_tb.sv

//--- logic/list_walk_ctrl.sv
`timescale 1ns/1ps

module list_walk_ctrl
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  list_walk_pkg::line_addr_t start_addr,
    input  list_walk_pkg::line_addr_t result_addr,
    input  list_walk_pkg::next_ptr_t  next_ptr,
    input  logic                      last_beat,
    input  list_walk_pkg::hash_t      hash,
    output list_walk_pkg::rd_req_t    rd_req,
    input  logic                      rd_full,
    output list_walk_pkg::wr_req_t    wr_req,
    input  logic                      wr_full,
    output list_walk_pkg::count_t     list_len
);
    import list_walk_pkg::*;

    walk_state_t state;

    // A read is owed to the host but not yet sent
    logic       rd_needed;
    // Address of the owed read, held while the host is full
    line_addr_t rd_addr;
    // The owed read goes out at this edge
    logic       rd_issue;

    assign rd_issue = rd_needed && !rd_full;

    // ==============================
    // Traversal FSM
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        state <= RUN;
                    end
                end
                RUN:
                begin
                    // Line 0 held a NULL pointer, so this record is the last
                    if (next_ptr.valid && next_ptr.end_of_list)
                    begin
                        state <= END_OF_LIST;
                    end
                end
                END_OF_LIST:
                begin
                    // Wait until the final data line has entered the hash
                    if (last_beat)
                    begin
                        state <= WRITE_RESULT;
                    end
                end
                WRITE_RESULT:
                begin
                    // The write leaves on the same edge as this transition
                    if (!wr_full)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ==============================
    // Read request
    // ==============================

    // Only one record is in flight, so a new need never overlaps a held one
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_needed <= 1'b0;
        end
        else if (rd_needed)
        begin
            // Keep the need for as long as the host stays full
            rd_needed <= rd_full;
        end
        else
        begin
            rd_needed <= start || (next_ptr.valid && !next_ptr.end_of_list);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rd_needed && (start || next_ptr.valid))
        begin
            rd_addr <= start ? start_addr : next_ptr.addr;
        end
    end

    // Registered issue so the request reflects rd_full of the previous cycle
    always_ff @(posedge clk)
    begin
        rd_req.addr <= rd_addr;
        if (reset)
        begin
            rd_req.valid <= 1'b0;
        end
        else
        begin
            rd_req.valid <= rd_issue;
        end
    end

    // Every issued read is one record of the list
    always_ff @(posedge clk)
    begin
        if (reset || start)
        begin
            list_len <= '0;
        end
        else if (rd_issue)
        begin
            list_len <= list_len + 1'b1;
        end
    end

    // ==============================
    // Result write
    // ==============================

    always_ff @(posedge clk)
    begin
        wr_req.addr <= result_addr;
        wr_req.hash <= hash;
        if (reset)
        begin
            wr_req.valid <= 1'b0;
        end
        else
        begin
            wr_req.valid <= (state == WRITE_RESULT) && !wr_full;
        end
    end

endmodule

//--- logic/list_walk_pkg.sv
`include "list_walk_cfg.svh"

package list_walk_pkg;

    // ==============================
    // Scalar types
    // ==============================

    // A full host byte address
    typedef logic [`LW_BYTE_ADDR_W-1:0] byte_addr_t;

    // Line address, which is a byte address with the offset bits removed
    typedef logic [`LW_BYTE_ADDR_W-`LW_LINE_OFS_W-1:0] line_addr_t;

    typedef logic [31:0] hash_t;
    typedef logic [`LW_CNT_W-1:0] count_t;

    // Index of a line inside one record
    typedef logic [$clog2(`LW_REC_LINES)-1:0] cl_num_t;

    // ==============================
    // Bus structures
    // ==============================

    // Host-driven half of APB
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`LW_APB_ADDR_W-1:0] paddr;
        logic [31:0]               pwdata;
    } apb_req_t;

    // Slave-driven half of APB
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // One request fetches a whole record starting at addr
    typedef struct packed {
        logic       valid;
        line_addr_t addr;
    } rd_req_t;

    // Lines come back one per beat and only the low word is kept
    typedef struct packed {
        logic        valid;
        cl_num_t     cl_num;
        logic [31:0] data;
    } rd_rsp_t;

    // Result write carries just the hash
    typedef struct packed {
        logic       valid;
        line_addr_t addr;
        hash_t      hash;
    } wr_req_t;

    // Decoded next pointer taken from line 0 of a record
    typedef struct packed {
        logic       valid;
        line_addr_t addr;
        logic       end_of_list;
    } next_ptr_t;

    // Traversal FSM states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        END_OF_LIST,
        WRITE_RESULT
    } walk_state_t;

    // ==============================
    // Address conversion
    // ==============================

    // Drop the byte-within-line bits
    function automatic line_addr_t to_line_addr(input byte_addr_t addr);
        return addr[`LW_BYTE_ADDR_W-1:`LW_LINE_OFS_W];
    endfunction

    // Append zero offset bits to get back a byte address
    function automatic byte_addr_t to_byte_addr(input line_addr_t addr);
        return {addr, {`LW_LINE_OFS_W{1'b0}}};
    endfunction

endpackage

//--- logic/list_walk_regs.sv
`timescale 1ns/1ps

`include "list_walk_cfg.svh"

module list_walk_regs
(
    input  logic                      clk,
    input  logic                      reset,
    input  list_walk_pkg::apb_req_t   apb_req,
    output list_walk_pkg::apb_rsp_t   apb_rsp,
    output list_walk_pkg::line_addr_t result_addr,
    output logic                      start,
    output list_walk_pkg::line_addr_t start_addr,
    input  list_walk_pkg::count_t     list_len,
    input  list_walk_pkg::count_t     data_cnt
);
    import list_walk_pkg::*;

    // High during the access phase of any transfer
    logic        access;
    // The offset maps to a register
    logic        reg_hit;
    // The mapped register can only be read
    logic        reg_ro;
    // Read data for the current offset
    logic [31:0] rd_data;
    // A write that lands on a writable register
    logic        wr_ok;

    // pready is tied high, so the access phase always ends in one cycle
    assign access = apb_req.psel && apb_req.penable;

    // ==============================
    // Offset decode
    // ==============================

    always_comb
    begin
        reg_hit = 1'b1;
        reg_ro  = 1'b0;
        rd_data = '0;
        case (apb_req.paddr)
            `LW_REG_RESULT:
            begin
                // Result address reads back in byte form
                rd_data = to_byte_addr(result_addr);
            end
            `LW_REG_START:
            begin
                // Reading START returns the last start address
                rd_data = to_byte_addr(start_addr);
            end
            `LW_REG_LIST_LEN:
            begin
                reg_ro  = 1'b1;
                rd_data = 32'(list_len);
            end
            `LW_REG_DATA_CNT:
            begin
                reg_ro  = 1'b1;
                rd_data = 32'(data_cnt);
            end
            default:
            begin
                reg_hit = 1'b0;
            end
        endcase
    end

    assign wr_ok = access && apb_req.pwrite && reg_hit && !reg_ro;

    // Response is combinational from the access phase
    always_comb
    begin
        apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;
        apb_rsp.pready  = 1'b1;
        // Unmapped offsets and writes to counters both raise an error
        apb_rsp.pslverr = access && (!reg_hit || (apb_req.pwrite && reg_ro));
    end

    // ==============================
    // Writable registers
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result_addr <= '0;
            start_addr  <= '0;
            start       <= 1'b0;
        end
        else
        begin
            // start is a one-cycle pulse in the cycle after the write
            start <= wr_ok && (apb_req.paddr == `LW_REG_START);

            if (wr_ok && (apb_req.paddr == `LW_REG_RESULT))
            begin
                result_addr <= to_line_addr(apb_req.pwdata);
            end

            // The written value of START is the head of the list
            if (wr_ok && (apb_req.paddr == `LW_REG_START))
            begin
                start_addr <= to_line_addr(apb_req.pwdata);
            end
        end
    end

endmodule

//--- logic/list_walk_rsp.sv
`timescale 1ns/1ps

`include "list_walk_cfg.svh"

module list_walk_rsp
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  list_walk_pkg::rd_rsp_t   rd_rsp,
    output list_walk_pkg::next_ptr_t next_ptr,
    output logic                     last_beat,
    output list_walk_pkg::hash_t     hash,
    output list_walk_pkg::count_t    data_cnt
);
    import list_walk_pkg::*;

    // Rotation applied to the hash before each new word is mixed in
    localparam int unsigned HASH_ROT = 5;

    // Registered copy of the incoming beat
    rd_rsp_t    rsp_q;
    // Line 0 of a record carries the next pointer
    logic       is_ptr;
    // Lines 1 to 3 carry data for the hash
    logic       data_en;
    // Pointer value converted to a line address
    line_addr_t ptr_addr;

    // Fold one data word into the running hash
    function automatic hash_t hash_fold(input hash_t h, input logic [31:0] word);
        hash_t rot;
        rot = (h << HASH_ROT) | (h >> ($bits(hash_t) - HASH_ROT));
        return rot ^ word;
    endfunction

    // ==============================
    // Response register
    // ==============================

    always_ff @(posedge clk)
    begin
        rsp_q.cl_num <= rd_rsp.cl_num;
        rsp_q.data   <= rd_rsp.data;
        if (reset)
        begin
            rsp_q.valid <= 1'b0;
        end
        else
        begin
            rsp_q.valid <= rd_rsp.valid;
        end
    end

    assign is_ptr   = rsp_q.valid && (rsp_q.cl_num == '0);
    assign data_en  = rsp_q.valid && (rsp_q.cl_num != '0);
    assign ptr_addr = to_line_addr(rsp_q.data);

    // ==============================
    // Pointer decode
    // ==============================

    // A zero pointer marks the last record
    always_comb
    begin
        next_ptr.valid       = is_ptr;
        next_ptr.addr        = ptr_addr;
        next_ptr.end_of_list = is_ptr && (ptr_addr == '0);
    end

    // Last line of a record, which ends the walk once the NULL pointer is seen
    assign last_beat = data_en && (rsp_q.cl_num == cl_num_t'(`LW_REC_LINES - 1));

    // ==============================
    // Hash and data counter
    // ==============================

    // Hash restarts from the seed for each walk
    always_ff @(posedge clk)
    begin
        if (reset || start)
        begin
            hash <= `LW_HASH_SEED;
        end
        else if (data_en)
        begin
            hash <= hash_fold(hash, rsp_q.data);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || start)
        begin
            data_cnt <= '0;
        end
        else if (data_en)
        begin
            data_cnt <= data_cnt + 1'b1;
        end
    end

endmodule

//--- logic/list_walk_top.sv
`timescale 1ns/1ps

module list_walk_top
(
    input  logic                    clk,
    input  logic                    reset,
    input  list_walk_pkg::apb_req_t apb_req,
    output list_walk_pkg::apb_rsp_t apb_rsp,
    output list_walk_pkg::rd_req_t  rd_req,
    input  logic                    rd_full,
    input  list_walk_pkg::rd_rsp_t  rd_rsp,
    output list_walk_pkg::wr_req_t  wr_req,
    input  logic                    wr_full
);
    import list_walk_pkg::*;

    // Configuration from the register block
    line_addr_t result_addr;
    logic       start;
    line_addr_t start_addr;

    // Status returned for APB reads
    count_t     list_len;
    count_t     data_cnt;

    // Response path toward the FSM
    hash_t      hash;
    next_ptr_t  next_ptr;
    logic       last_beat;

    // APB register block
    list_walk_regs regs_i
    (
        .clk,
        .reset,
        .apb_req,
        .apb_rsp,
        .result_addr,
        .start,
        .start_addr,
        .list_len,
        .data_cnt
    );

    // Traversal FSM and request issue
    list_walk_ctrl ctrl_i
    (
        .clk,
        .reset,
        .start,
        .start_addr,
        .result_addr,
        .next_ptr,
        .last_beat,
        .hash,
        .rd_req,
        .rd_full,
        .wr_req,
        .wr_full,
        .list_len
    );

    // Read response decode and hashing
    list_walk_rsp rsp_i
    (
        .clk,
        .reset,
        .start,
        .rd_rsp,
        .next_ptr,
        .last_beat,
        .hash,
        .data_cnt
    );

endmodule

//--- sim/list_walk_sva.sv
`timescale 1ns/1ps

module list_walk_sva
(
    input logic                        clk,
    input logic                        reset,
    input list_walk_pkg::rd_req_t      rd_req,
    input logic                        rd_full,
    input list_walk_pkg::wr_req_t      wr_req,
    input list_walk_pkg::walk_state_t  state
);
    import list_walk_pkg::*;

    // The walker owes the host its result once the NULL pointer has been seen
    logic write_pending;

    // Assertion failures seen so far
    int fail_count = 0;

    assign write_pending = (state == END_OF_LIST) || (state == WRITE_RESULT);

    // ==============================
    // Memory port rules
    // ==============================

    // A read may only go out after a cycle where the host had room
    read_after_full: assert property (@(posedge clk) disable iff (reset)
        rd_req.valid |-> !$past(rd_full))
        else
        begin
            fail_count++;
            $error("read request issued in the cycle after rd_full was high");
        end

    // The result write is a single-cycle pulse
    write_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wr_req.valid |=> !wr_req.valid)
        else
        begin
            fail_count++;
            $error("result write stayed valid for two cycles");
        end

    // No further record is fetched once the walk is heading for its write
    read_during_write: assert property (@(posedge clk) disable iff (reset)
        rd_req.valid |-> !write_pending)
        else
        begin
            fail_count++;
            $error("read request issued while the result write was pending");
        end

endmodule

bind list_walk_top list_walk_sva sva_i
(
    .clk(clk),
    .reset(reset),
    .rd_req(rd_req),
    .rd_full(rd_full),
    .wr_req(wr_req),
    .state(ctrl_i.state)
);

//--- sim/list_walk_tb.sv
`timescale 1ns/1ps

`include "list_walk_cfg.svh"

module list_walk_tb;
    import list_walk_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RNG_SEED     = 86;
    localparam int NUM_WALKS    = 10;
    localparam int MAX_RECS     = 8;
    localparam int DATA_LINES   = `LW_REC_LINES - 1;
    localparam int WALK_TIMEOUT = 4000;

    logic     clk = 1'b0;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    rd_req_t  rd_req;
    logic     rd_full;
    rd_rsp_t  rd_rsp;
    wr_req_t  wr_req;
    logic     wr_full;

    // Model of the list for the current walk
    int          rec_count;
    line_addr_t  chain [MAX_RECS];
    logic [31:0] words [MAX_RECS][DATA_LINES];
    hash_t       exp_hash;
    line_addr_t  result_line;

    // Progress seen on the memory ports
    int     rd_idx;
    count_t wr_count;
    int     pend_q[$];

    // Write-side full level seen by the DUT at the last rising edge
    logic wr_full_q;

    // Chance in percent that the host reports full in a cycle
    int full_pct;

    list_walk_top dut_i
    (
        .clk(clk),
        .reset(reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .rd_req(rd_req),
        .rd_full(rd_full),
        .rd_rsp(rd_rsp),
        .wr_req(wr_req),
        .wr_full(wr_full)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Reporting and compare tasks
    // ==============================

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(input string name, input line_addr_t expected,
                              input line_addr_t actual);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
            stop_on_error("line address check failed");
        end
    endtask

    task automatic check_hash(input string name, input hash_t expected, input hash_t actual);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
            stop_on_error("hash check failed");
        end
    endtask

    task automatic check_count(input string name, input count_t expected, input count_t actual);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            stop_on_error("counter check failed");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
            stop_on_error("APB response flag check failed");
        end
    endtask

    // ==============================
    // List model
    // ==============================

    // New hash is the old one rotated left by 5, XORed with the word
    function automatic hash_t hash_step(input hash_t h, input logic [31:0] word);
        return {h[26:0], h[31:27]} ^ word;
    endfunction

    // Low word of one line of record idx as the host memory holds it
    function automatic logic [31:0] line_word(input int idx, input int beat);
        if (beat != 0)
        begin
            return words[idx][beat - 1];
        end
        else if (idx + 1 < rec_count)
        begin
            return {chain[idx + 1], {`LW_LINE_OFS_W{1'b0}}};
        end
        return 32'h0;
    endfunction

    // Random records at distinct, record-aligned, non-zero line addresses
    task automatic build_list();
        line_addr_t cand;
        logic       clash;
        rec_count = $urandom_range(1, MAX_RECS);
        for (int i = 0; i < rec_count; i++)
        begin
            do
            begin
                cand  = line_addr_t'($urandom) & ~line_addr_t'(`LW_REC_LINES - 1);
                clash = (cand == '0);
                for (int j = 0; j < i; j++)
                begin
                    if (chain[j] == cand)
                    begin
                        clash = 1'b1;
                    end
                end
            end
            while (clash);
            chain[i] = cand;
            for (int w = 0; w < DATA_LINES; w++)
            begin
                words[i][w] = $urandom;
            end
        end
        exp_hash = `LW_HASH_SEED;
        for (int i = 0; i < rec_count; i++)
        begin
            for (int w = 0; w < DATA_LINES; w++)
            begin
                exp_hash = hash_step(exp_hash, words[i][w]);
            end
        end
    endtask

    // ==============================
    // Host side of the memory ports
    // ==============================

    // Random back-pressure on both channels
    always @(negedge clk)
    begin
        rd_full = ($urandom_range(0, 99) < full_pct);
        wr_full = ($urandom_range(0, 99) < full_pct);
    end

    always @(posedge clk)
    begin
        wr_full_q <= wr_full;
    end

    // Outputs are registered, so they are steady at the falling edge
    always @(negedge clk)
    begin
        if (dut_i.sva_i.fail_count != 0)
        begin
            stop_on_error("a bound assertion on the memory ports failed");
        end
        if (!reset && rd_req.valid)
        begin
            if (rd_idx >= rec_count)
            begin
                stop_on_error("read request issued past the last record of the list");
            end
            else
            begin
                check_addr("rd_req.addr", chain[rd_idx], rd_req.addr);
                pend_q.push_back(rd_idx);
                rd_idx++;
            end
        end
        if (!reset && wr_req.valid)
        begin
            if (wr_full_q)
            begin
                stop_on_error("result write issued in the cycle after wr_full was high");
            end
            wr_count++;
            check_addr("wr_req.addr", result_line, wr_req.addr);
            check_hash("wr_req.hash", exp_hash, wr_req.hash);
        end
    end

    // Each record returns its four lines in order with random gaps
    initial
    begin
        int idx;
        int gap;
        forever
        begin
            @(posedge clk);
            if (pend_q.size() != 0)
            begin
                idx = pend_q.pop_front();
                for (int beat = 0; beat < `LW_REC_LINES; beat++)
                begin
                    gap = $urandom_range(0, 3);
                    repeat (gap)
                    begin
                        @(negedge clk);
                        rd_rsp.valid = 1'b0;
                    end
                    @(negedge clk);
                    rd_rsp.valid  = 1'b1;
                    rd_rsp.cl_num = cl_num_t'(beat);
                    rd_rsp.data   = line_word(idx, beat);
                end
                @(negedge clk);
                rd_rsp.valid = 1'b0;
            end
        end
    end

    // ==============================
    // APB driver
    // ==============================

    // Setup phase, then access phase sampled mid-way through the low clock half
    task automatic apb_access(input logic write, input logic [`LW_APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);
        // Every access phase completes in its own cycle
        check_flag("apb_rsp.pready", 1'b1, apb_rsp.pready);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic wait_for_write();
        int cycles;
        cycles = 0;
        while (wr_count == 0)
        begin
            if (cycles >= WALK_TIMEOUT)
            begin
                stop_on_error("timeout: the walk never issued its result write");
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        logic [31:0] rdata;
        logic [31:0] rbyte;
        logic        err;
        void'($urandom(RNG_SEED));
        full_pct    = 0;
        rec_count   = 0;
        rd_idx      = 0;
        wr_count    = '0;
        exp_hash    = '0;
        result_line = '0;
        reset       = 1'b1;
        apb_req     = '0;
        rd_full     = 1'b0;
        wr_full     = 1'b0;
        rd_rsp      = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Register block on its own, with random low bits in the address
        rbyte = $urandom;
        apb_access(1'b1, `LW_REG_RESULT, rbyte, rdata, err);
        check_flag("apb_rsp.pslverr on write to RESULT", 1'b0, err);
        apb_access(1'b0, `LW_REG_RESULT, 32'h0, rdata, err);
        check_flag("apb_rsp.pslverr on read of RESULT", 1'b0, err);
        check_addr("RESULT readback", rbyte[31:`LW_LINE_OFS_W], rdata[31:`LW_LINE_OFS_W]);
        if (rdata[`LW_LINE_OFS_W-1:0] !== '0)
        begin
            $display("mismatch at %0t: RESULT readback low bits expected 0x0, got 0x%h", $time,
                     rdata[`LW_LINE_OFS_W-1:0]);
            stop_on_error("RESULT readback kept its byte-within-line bits");
        end
        apb_access(1'b0, 8'h10, 32'h0, rdata, err);
        check_flag("apb_rsp.pslverr on read of unmapped offset 0x10", 1'b1, err);
        apb_access(1'b1, `LW_REG_LIST_LEN, 32'h5, rdata, err);
        check_flag("apb_rsp.pslverr on write to LIST_LEN", 1'b1, err);

        for (int walk = 0; walk < NUM_WALKS; walk++)
        begin
            // Shared model state only changes on the rising edge
            @(posedge clk);
            build_list();
            full_pct    = (walk == 0) ? 0 : $urandom_range(10, 60);
            rbyte       = $urandom;
            result_line = rbyte[31:`LW_LINE_OFS_W];
            rd_idx      = 0;
            wr_count    = '0;

            apb_access(1'b1, `LW_REG_RESULT, rbyte, rdata, err);
            check_flag("apb_rsp.pslverr on write to RESULT", 1'b0, err);
            apb_access(1'b1, `LW_REG_START, {chain[0], {`LW_LINE_OFS_W{1'b0}}}, rdata, err);
            check_flag("apb_rsp.pslverr on write to START", 1'b0, err);
            wait_for_write();
            check_count("read requests", count_t'(rec_count), count_t'(rd_idx));

            apb_access(1'b0, `LW_REG_LIST_LEN, 32'h0, rdata, err);
            check_flag("apb_rsp.pslverr on read of LIST_LEN", 1'b0, err);
            check_count("LIST_LEN", count_t'(rec_count), rdata[`LW_CNT_W-1:0]);
            apb_access(1'b0, `LW_REG_DATA_CNT, 32'h0, rdata, err);
            check_flag("apb_rsp.pslverr on read of DATA_CNT", 1'b0, err);
            check_count("DATA_CNT", count_t'(DATA_LINES * rec_count), rdata[`LW_CNT_W-1:0]);

            // A second write would have landed during the counter reads
            check_count("result writes", count_t'(1), wr_count);
        end

        if (dut_i.sva_i.fail_count == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            stop_on_error("a bound assertion on the memory ports failed");
        end
    end

endmodule
